// ==== tb.f ====
+incdir+.
ifid_pkg.sv
instr_decoder.sv
ifid_pipe_reg.sv
ifid_stage.sv
tb_clock_gen.sv
ifid_stage_tb.sv

// ==== Bender.yml ====
package:
  name: ifid_stage

export_include_dirs:
  - .

sources:
  - ifid_pkg.sv
  - instr_decoder.sv
  - ifid_pipe_reg.sv
  - ifid_stage.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - ifid_stage_tb.sv

// ==== ifid_stage_tb.sv ====
////////////////////
// directed testbench for the IF/ID stage
// each test drives instructions and compares against a decode model
////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "ifid_defines.svh"

module ifid_stage_tb;

    import ifid_pkg::*;

    localparam int TEST_CYCLES = 100;    // about 41 instructions at 2 cycles, plus reset

    logic clk;
    logic rst;
    logic branch_taken;
    logic load_true;
    logic flush;
    instr_t instr;
    data_t op1_data, op2_data, op3_data;
    data_t op1_data_q, op2_data_q, op3_data_q;
    op_addr_t op1_addr, op2_addr, op1_addr_q, op2_addr_q;
    reg_addr_t op3_addr, op3_addr_q, res_addr_q;
    ctrl_word_t ctrl;
    pc_t pred_next_pc;
    pc_t exp_pc;                         // model of the held jump target
    ctrl_word_t last_ctrl;               // word the register holds until the next edge
    int unsigned seed;
    int errors;

    tb_clock_gen clock_inst (.clk(clk));

    ifid_stage ifid_stage_inst (
        .clk(clk), .rst(rst), .instr(instr), .branch_taken(branch_taken),
        .op1_data(op1_data), .op2_data(op2_data), .op3_data(op3_data),
        .op1_addr(op1_addr), .op2_addr(op2_addr), .op3_addr(op3_addr),
        .load_true(load_true), .ctrl(ctrl), .flush(flush), .pred_next_pc(pred_next_pc),
        .op1_addr_q(op1_addr_q), .op2_addr_q(op2_addr_q), .op3_addr_q(op3_addr_q),
        .res_addr_q(res_addr_q), .op1_data_q(op1_data_q), .op2_data_q(op2_data_q),
        .op3_data_q(op3_data_q)
    );

    ////////////////////
    // reference decode
    ////////////////////
    // built flag by flag from the decode table
    function automatic ctrl_word_t expected_ctrl(input instr_t w);
        ctrl_word_t c;
        opcode_t op;
        op = w[15:11];
        c = '0;
        c[`CW_IMM_LSB +: `IFID_IMM_W] = w[7:0];
        c[`CW_OP1_FILE] = w[3];
        c[`CW_OP2_FILE] = w[7];
        c[`CW_ADD] = (op == `OPC_ADD) || (op == `OPC_SUB) || (op == `OPC_CMP)
                     || (op == `OPC_ADDM) || (op == `OPC_SUBM);
        c[`CW_OR] = (op == `OPC_OR);
        c[`CW_NOT] = (op == `OPC_NOT);
        c[`CW_ANDBIT] = (op == `OPC_ANDBIT);
        c[`CW_ORBIT] = (op == `OPC_ORBIT);
        c[`CW_NOTBIT] = (op == `OPC_NOTBIT);
        c[`CW_AND] = (op == `OPC_AND);
        c[`CW_CARRY_IN] = (op == `OPC_SUB) || (op == `OPC_CMP);
        c[`CW_OP2_COMPL] = (op == `OPC_SUB) || (op == `OPC_CMP) || (op == `OPC_SUBM);
        c[`CW_JUMP] = (op == `OPC_JMP) || (op >= `OPC_JMPGT && op <= `OPC_JMPC);
        c[`CW_COMPARE] = (op == `OPC_CMP);
        c[`CW_SHL] = (op == `OPC_SHL);
        c[`CW_LOGIC] = (op >= `OPC_AND && op <= `OPC_NOT)
                       || (op >= `OPC_ANDBIT && op <= `OPC_NOTBIT);
        c[`CW_STORE] = (op == `OPC_RSTORE);
        c[`CW_LOAD] = (op == `OPC_RLOAD);
        c[`CW_WRITE_RF] = (op >= `OPC_ADD && op <= `OPC_SHL) || (op == `OPC_RLOAD)
                          || (op >= `OPC_ANDBIT && op <= `OPC_NOTBIT) || (op == `OPC_LDI)
                          || (op >= `OPC_ADDM && op <= `OPC_MULM) || (op == `OPC_RLLM)
                          || ((op == `OPC_UNRLL || op == `OPC_UNRLU) && w[3]);
        c[`CW_JGT] = (op == `OPC_JMPGT);
        c[`CW_JLT] = (op == `OPC_JMPLT);
        c[`CW_JEQ] = (op == `OPC_JMPEQ);
        c[`CW_JCARRY] = (op == `OPC_JMPC);
        c[`CW_JUNCOND] = (op == `OPC_JMP);
        c[`CW_LD_IMM] = (op == `OPC_LDI);
        c[`CW_MUL] = (op == `OPC_MULM);
        c[`CW_RNS_ALU] = (op >= `OPC_ADDM && op <= `OPC_MULM);
        c[`CW_UNRL] = (op == `OPC_UNRLL) || (op == `OPC_UNRLU);
        c[`CW_RLLM] = (op == `OPC_RLLM);
        c[`CW_RNS_DEST] = (op >= `OPC_ADDM && op <= `OPC_MULM) || (op == `OPC_RLLM);
        c[`CW_UNRL_LOWER] = (op == `OPC_UNRLL);
        return c;
    endfunction

    // opcode with random register fields
    function automatic instr_t make_instr(input opcode_t op);
        instr_t w;
        w = $urandom;
        w[15:11] = op;
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        errors++;
        $display("error at %0t: %s expected %0h got %0h", $time, name, exp, act);
    endtask

    ////////////////////
    // one instruction
    ////////////////////
    // drive, check forwarding outputs, then the registered side one edge later
    task automatic run_instr(input instr_t w);
        ctrl_word_t exp_ctrl;
        logic bt;
        data_t d1, d2, d3;
        reg_addr_t exp_op3, exp_res;
        exp_ctrl = expected_ctrl(w);
        bt = $urandom % 2;
        d1 = $urandom;
        d2 = $urandom;
        d3 = $urandom;
        exp_op3 = (w[15:11] == `OPC_RSTORE) ? w[10:8] : 3'd0;   // store source
        exp_res = (w[15:11] == `OPC_RSTORE) ? 3'd0 : w[10:8];
        @(posedge clk);
        instr <= w;
        branch_taken <= bt;
        op1_data <= d1;
        op2_data <= d2;
        op3_data <= d3;
        @(negedge clk);    // combinational path settled
        if (op1_addr !== w[3:0])
            report_mismatch("op1_addr", w[3:0], op1_addr);
        if (op2_addr !== w[7:4])
            report_mismatch("op2_addr", w[7:4], op2_addr);
        if (op3_addr !== exp_op3)
            report_mismatch("op3_addr", exp_op3, op3_addr);
        if (load_true !== (w[15:11] == `OPC_RLOAD))
            report_mismatch("load_true", w[15:11] == `OPC_RLOAD, load_true);
        if (ctrl !== last_ctrl)    // new word must not show before the edge
            report_mismatch("ctrl before capture", last_ctrl, ctrl);
        @(posedge clk);    // dut captures here
        @(negedge clk);
        if (exp_ctrl[`CW_JUMP])
            exp_pc = w[9:0];
        if (ctrl !== exp_ctrl)
            report_mismatch("ctrl", exp_ctrl, ctrl);
        if (flush !== bt)
            report_mismatch("flush", bt, flush);
        if (pred_next_pc !== exp_pc)
            report_mismatch("pred_next_pc", exp_pc, pred_next_pc);
        if (op1_addr_q !== w[3:0])
            report_mismatch("op1_addr_q", w[3:0], op1_addr_q);
        if (op2_addr_q !== w[7:4])
            report_mismatch("op2_addr_q", w[7:4], op2_addr_q);
        if (op3_addr_q !== exp_op3)
            report_mismatch("op3_addr_q", exp_op3, op3_addr_q);
        if (res_addr_q !== exp_res)
            report_mismatch("res_addr_q", exp_res, res_addr_q);
        if ({op1_data_q, op2_data_q, op3_data_q} !== {d1, d2, d3})
            report_mismatch("op data q", {d1, d2, d3}, {op1_data_q, op2_data_q, op3_data_q});
        last_ctrl = exp_ctrl;
    endtask

    ////////////////////
    // tests
    ////////////////////
    task automatic reset_test();
        repeat (3) @(posedge clk);
        rst <= 1'b0;    // third edge still sees reset
        @(negedge clk);
        exp_pc = '0;
        last_ctrl = '0;
        if ({ctrl, flush, pred_next_pc, op1_addr_q, op2_addr_q, op3_addr_q, res_addr_q,
             op1_data_q, op2_data_q, op3_data_q} !== '0)
            report_mismatch("registered outputs after reset", 0,
                            {ctrl, flush, pred_next_pc, op1_addr_q, op2_addr_q,
                             op3_addr_q, res_addr_q, op1_data_q, op2_data_q, op3_data_q});
    endtask

    task automatic alu_decode_test();
        for (int op = `OPC_ADD; op <= `OPC_CMP; op++)
        begin
            if (op != `OPC_JMP && op != `OPC_RLOAD && op != `OPC_RSTORE)
                run_instr(make_instr(op));
        end
    endtask

    task automatic memory_decode_test();
        repeat (2) run_instr(make_instr(`OPC_RLOAD));
        repeat (2) run_instr(make_instr(`OPC_RSTORE));
    endtask

    task automatic jump_test();
        for (int op = `OPC_JMPGT; op <= `OPC_JMPC + 1; op++)
        begin
            // last pass reuses the slot for the unconditional jump
            run_instr(make_instr(op > `OPC_JMPC ? `OPC_JMP : op));
            run_instr(make_instr(`OPC_ADD));    // target must hold
        end
    endtask

    task automatic rns_ldi_test();
        instr_t w;
        run_instr(make_instr(`OPC_ADDM));
        run_instr(make_instr(`OPC_SUBM));
        run_instr(make_instr(`OPC_MULM));
        run_instr(make_instr(`OPC_RLLM));
        for (int i = 0; i < 4; i++)
        begin
            w = make_instr(i < 2 ? `OPC_UNRLL : `OPC_UNRLU);
            w[3] = i[0];    // op1 file bit both ways
            run_instr(w);
        end
        run_instr(make_instr(`OPC_LDI));
        run_instr(make_instr(5'd22));    // unused slot
        run_instr(make_instr(`OPC_NOP));
    endtask

    task automatic flush_data_test();
        repeat (6) run_instr(make_instr(`OPC_NOP));
    endtask

    ////////////////////
    // run control
    ////////////////////
    initial
    begin
        rst = 1'b1;
        instr = '0;
        branch_taken = 1'b0;
        op1_data = '0;
        op2_data = '0;
        op3_data = '0;
        exp_pc = '0;
        last_ctrl = '0;
        errors = 0;
        seed = 32'h1aef_0dea;
        void'($urandom(seed));
        reset_test();
        alu_decode_test();
        memory_decode_test();
        jump_test();
        rns_ldi_test();
        flush_data_test();
        $display("tests done, %0d errors", errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        #(TEST_CYCLES * 100 + 2000);    // test length plus margin
        $display("timeout: the tests did not finish in the expected time");
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
////////////////////
// free-running testbench clock, 100 ns period
////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;    // half period

endmodule

`default_nettype wire

// ==== ifid_stage.sv ====
////////////////////
// IF/ID pipeline stage top
// decoder feeding the boundary register
////////////////////
`timescale 1ns/100ps
`default_nettype none

module ifid_stage (
    input  wire                       clk,
    input  wire                       rst,
    input  wire ifid_pkg::instr_t     instr,          // from instruction memory
    input  wire                       branch_taken,   // from execute
    input  wire ifid_pkg::data_t      op1_data,       // from forwarding unit
    input  wire ifid_pkg::data_t      op2_data,
    input  wire ifid_pkg::data_t      op3_data,
    // combinational, to forwarding unit
    output wire ifid_pkg::op_addr_t   op1_addr,
    output wire ifid_pkg::op_addr_t   op2_addr,
    output wire ifid_pkg::reg_addr_t  op3_addr,
    output wire                       load_true,
    // registered, to execute
    output wire ifid_pkg::ctrl_word_t ctrl,
    output wire                       flush,
    output wire ifid_pkg::pc_t        pred_next_pc,
    output wire ifid_pkg::op_addr_t   op1_addr_q,
    output wire ifid_pkg::op_addr_t   op2_addr_q,
    output wire ifid_pkg::reg_addr_t  op3_addr_q,
    output wire ifid_pkg::reg_addr_t  res_addr_q,
    output wire ifid_pkg::data_t      op1_data_q,
    output wire ifid_pkg::data_t      op2_data_q,
    output wire ifid_pkg::data_t      op3_data_q
);

    import ifid_pkg::*;

    ctrl_word_t ctrl_next;     // decoder to register
    reg_addr_t  res_addr;      // destination before registering
    pc_t        jump_target;

    instr_decoder decoder_inst (
        .instr       (instr),
        .ctrl_next   (ctrl_next),
        .op1_addr    (op1_addr),
        .op2_addr    (op2_addr),
        .op3_addr    (op3_addr),
        .res_addr    (res_addr),
        .load_true   (load_true),
        .jump_target (jump_target)
    );

    ifid_pipe_reg pipe_reg_inst (
        .clk          (clk),
        .rst          (rst),
        .branch_taken (branch_taken),
        .ctrl_next    (ctrl_next),
        .op1_addr     (op1_addr),
        .op2_addr     (op2_addr),
        .op3_addr     (op3_addr),
        .res_addr     (res_addr),
        .jump_target  (jump_target),
        .op1_data     (op1_data),
        .op2_data     (op2_data),
        .op3_data     (op3_data),
        .ctrl         (ctrl),
        .flush        (flush),
        .pred_next_pc (pred_next_pc),
        .op1_addr_q   (op1_addr_q),
        .op2_addr_q   (op2_addr_q),
        .op3_addr_q   (op3_addr_q),
        .res_addr_q   (res_addr_q),
        .op1_data_q   (op1_data_q),
        .op2_data_q   (op2_data_q),
        .op3_data_q   (op3_data_q)
    );

endmodule

`default_nettype wire

// ==== ifid_pipe_reg.sv ====
////////////////////
// IF/ID boundary register between decode and execute
// one instruction per cycle, synchronous reset clears all outputs
////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "ifid_defines.svh"

module ifid_pipe_reg (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       branch_taken,   // from execute
    input  wire ifid_pkg::ctrl_word_t ctrl_next,
    input  wire ifid_pkg::op_addr_t   op1_addr,
    input  wire ifid_pkg::op_addr_t   op2_addr,
    input  wire ifid_pkg::reg_addr_t  op3_addr,
    input  wire ifid_pkg::reg_addr_t  res_addr,
    input  wire ifid_pkg::pc_t        jump_target,
    input  wire ifid_pkg::data_t      op1_data,       // from forwarding unit
    input  wire ifid_pkg::data_t      op2_data,
    input  wire ifid_pkg::data_t      op3_data,
    output ifid_pkg::ctrl_word_t      ctrl,
    output logic                      flush,          // kill the instruction now in execute
    output ifid_pkg::pc_t             pred_next_pc,   // last decoded jump target
    output ifid_pkg::op_addr_t        op1_addr_q,
    output ifid_pkg::op_addr_t        op2_addr_q,
    output ifid_pkg::reg_addr_t       op3_addr_q,
    output ifid_pkg::reg_addr_t       res_addr_q,
    output ifid_pkg::data_t           op1_data_q,
    output ifid_pkg::data_t           op2_data_q,
    output ifid_pkg::data_t           op3_data_q
);

    ////////////////////
    // boundary register
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ctrl         <= '0;
            flush        <= 1'b0;
            pred_next_pc <= '0;
            op1_addr_q   <= '0;
            op2_addr_q   <= '0;
            op3_addr_q   <= '0;
            res_addr_q   <= '0;
            op1_data_q   <= '0;
            op2_data_q   <= '0;
            op3_data_q   <= '0;
        end
        else
        begin
            ctrl       <= ctrl_next;
            flush      <= branch_taken;    // one cycle behind execute
            op1_addr_q <= op1_addr;
            op2_addr_q <= op2_addr;
            op3_addr_q <= op3_addr;
            res_addr_q <= res_addr;
            op1_data_q <= op1_data;
            op2_data_q <= op2_data;
            op3_data_q <= op3_data;

            // target only moves on a jump and holds across other opcodes
            if (ctrl_next[`CW_JUMP])
            begin
                pred_next_pc <= jump_target;
            end
        end
    end

endmodule

`default_nettype wire

// ==== instr_decoder.sv ====
////////////////////
// combinational decode of one instruction word
// feeds the forwarding unit directly and the IF/ID register
////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "ifid_defines.svh"

module instr_decoder (
    input  wire ifid_pkg::instr_t    instr,        // word from instruction memory
    output ifid_pkg::ctrl_word_t     ctrl_next,    // decoded control word
    output ifid_pkg::op_addr_t       op1_addr,     // to forwarding unit
    output ifid_pkg::op_addr_t       op2_addr,     // to forwarding unit
    output ifid_pkg::reg_addr_t      op3_addr,     // store source, else 0
    output ifid_pkg::reg_addr_t      res_addr,     // destination, 0 on store
    output logic                     load_true,    // to forwarding unit
    output ifid_pkg::pc_t            jump_target   // low bits of the word
);

    import ifid_pkg::*;

    opcode_t   opcode;
    reg_addr_t res_field;
    imm_t      imm;

    ////////////////////
    // field split
    ////////////////////
    assign opcode      = instr[15:11];
    assign res_field   = instr[10:8];
    assign imm         = instr[7:0];    // overlaps both operand addresses
    assign op2_addr    = instr[7:4];
    assign op1_addr    = instr[3:0];
    assign jump_target = instr[9:0];    // overlaps result field

    // store uses the result field as a source register
    assign res_addr  = (opcode == `OPC_RSTORE) ? '0 : res_field;
    assign op3_addr  = (opcode == `OPC_RSTORE) ? res_field : '0;
    assign load_true = ctrl_next[`CW_LOAD];

    ////////////////////
    // opcode decode
    ////////////////////
    always_comb
    begin
        ctrl_next = '0;
        ctrl_next[`CW_IMM_LSB +: `IFID_IMM_W] = imm;     // carried on every opcode
        ctrl_next[`CW_OP1_FILE] = op1_addr[`IFID_OP_ADDR_W-1];
        ctrl_next[`CW_OP2_FILE] = op2_addr[`IFID_OP_ADDR_W-1];

        case (opcode)
            `OPC_ADD:
            begin
                ctrl_next[`CW_ADD]      = 1'b1;
                ctrl_next[`CW_WRITE_RF] = 1'b1;
            end
            `OPC_SUB, `OPC_CMP:
            begin
                // a - b as a + ~b + 1
                ctrl_next[`CW_ADD]       = 1'b1;
                ctrl_next[`CW_CARRY_IN]  = 1'b1;
                ctrl_next[`CW_OP2_COMPL] = 1'b1;
                ctrl_next[`CW_COMPARE]   = (opcode == `OPC_CMP);   // flags only
                ctrl_next[`CW_WRITE_RF]  = (opcode == `OPC_SUB);
            end
            `OPC_AND, `OPC_OR, `OPC_NOT, `OPC_ANDBIT, `OPC_ORBIT, `OPC_NOTBIT:
            begin
                ctrl_next[`CW_AND]      = (opcode == `OPC_AND);
                ctrl_next[`CW_OR]       = (opcode == `OPC_OR);
                ctrl_next[`CW_NOT]      = (opcode == `OPC_NOT);
                ctrl_next[`CW_ANDBIT]   = (opcode == `OPC_ANDBIT);
                ctrl_next[`CW_ORBIT]    = (opcode == `OPC_ORBIT);
                ctrl_next[`CW_NOTBIT]   = (opcode == `OPC_NOTBIT);
                ctrl_next[`CW_LOGIC]    = 1'b1;    // selects the logic unit result
                ctrl_next[`CW_WRITE_RF] = 1'b1;
            end
            `OPC_SHL:
            begin
                ctrl_next[`CW_SHL]      = 1'b1;
                ctrl_next[`CW_WRITE_RF] = 1'b1;
            end
            `OPC_JMP, `OPC_JMPGT, `OPC_JMPLT, `OPC_JMPEQ, `OPC_JMPC:
            begin
                ctrl_next[`CW_JUMP]    = 1'b1;     // target is picked up by the register
                ctrl_next[`CW_JUNCOND] = (opcode == `OPC_JMP);
                ctrl_next[`CW_JGT]     = (opcode == `OPC_JMPGT);
                ctrl_next[`CW_JLT]     = (opcode == `OPC_JMPLT);
                ctrl_next[`CW_JEQ]     = (opcode == `OPC_JMPEQ);
                ctrl_next[`CW_JCARRY]  = (opcode == `OPC_JMPC);
            end
            `OPC_RLOAD:
            begin
                // address comes from the op1/op2 register pair
                ctrl_next[`CW_LOAD]     = 1'b1;
                ctrl_next[`CW_WRITE_RF] = 1'b1;
            end
            `OPC_RSTORE:
                ctrl_next[`CW_STORE] = 1'b1;       // no register write
            `OPC_LDI:
            begin
                ctrl_next[`CW_LD_IMM]   = 1'b1;
                ctrl_next[`CW_WRITE_RF] = 1'b1;
            end
            `OPC_ADDM, `OPC_SUBM, `OPC_MULM:
            begin
                // modular ops always land in the rns file
                ctrl_next[`CW_RNS_ALU]   = 1'b1;
                ctrl_next[`CW_RNS_DEST]  = 1'b1;
                ctrl_next[`CW_WRITE_RF]  = 1'b1;
                ctrl_next[`CW_ADD]       = (opcode != `OPC_MULM);
                ctrl_next[`CW_OP2_COMPL] = (opcode == `OPC_SUBM);  // marks subtract only
                ctrl_next[`CW_MUL]       = (opcode == `OPC_MULM);
            end
            `OPC_UNRLL, `OPC_UNRLU:
            begin
                // only write back when the source really is an rns register
                ctrl_next[`CW_UNRL]       = 1'b1;
                ctrl_next[`CW_UNRL_LOWER] = (opcode == `OPC_UNRLL);
                ctrl_next[`CW_WRITE_RF]   = op1_addr[`IFID_OP_ADDR_W-1];
            end
            `OPC_RLLM:
            begin
                ctrl_next[`CW_RLLM]     = 1'b1;    // two int regs into one rns reg
                ctrl_next[`CW_RNS_DEST] = 1'b1;
                ctrl_next[`CW_WRITE_RF] = 1'b1;
            end
            default:
            begin
                // nop and the unused opcode keep only imm and file bits
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== ifid_pkg.sv ====
////////////////////
// vector types shared by the IF/ID stage and its testbench
////////////////////
`default_nettype none

`include "ifid_defines.svh"

package ifid_pkg;

    // whole fetched word
    typedef logic [`IFID_INSTR_W-1:0]    instr_t;

    // decoded fields
    typedef logic [`IFID_OPC_W-1:0]      opcode_t;
    typedef logic [`IFID_REG_ADDR_W-1:0] reg_addr_t;  // index inside one file
    typedef logic [`IFID_OP_ADDR_W-1:0]  op_addr_t;   // {file bit, index}
    typedef logic [`IFID_IMM_W-1:0]      imm_t;

    // operand data, single domain only
    typedef logic [`IFID_DATA_W-1:0]     data_t;

    // instruction address
    typedef logic [`IFID_PC_W-1:0]       pc_t;

    ////////////////////
    // control word
    ////////////////////
    // flags plus immediate as one vector so it crosses into execute
    // as a single pipeline register
    typedef logic [`IFID_CTRL_W-1:0]     ctrl_word_t;

endpackage

`default_nettype wire

// ==== ifid_defines.svh ====
////////////////////
// widths, opcode values and control-word bit positions of the IF/ID stage
// include wherever one of these names is used
////////////////////
`ifndef IFID_DEFINES_SVH
`define IFID_DEFINES_SVH

// field and bus widths
`define IFID_INSTR_W     16
`define IFID_OPC_W       5
`define IFID_PC_W        10
`define IFID_DATA_W      8
`define IFID_REG_ADDR_W  3
`define IFID_OP_ADDR_W   4     // msb is the file bit, 1 = rns
`define IFID_IMM_W       8
`define IFID_CTRL_W      38

// opcodes
`define OPC_NOP     5'd0
`define OPC_ADD     5'd1
`define OPC_SUB     5'd2
`define OPC_AND     5'd3
`define OPC_OR      5'd4
`define OPC_NOT     5'd5
`define OPC_SHL     5'd6
`define OPC_JMP     5'd7
`define OPC_RLOAD   5'd8
`define OPC_RSTORE  5'd9
`define OPC_ANDBIT  5'd10
`define OPC_ORBIT   5'd11
`define OPC_NOTBIT  5'd12
`define OPC_CMP     5'd13
`define OPC_JMPGT   5'd14
`define OPC_JMPLT   5'd15
`define OPC_JMPEQ   5'd16
`define OPC_JMPC    5'd17
`define OPC_LDI     5'd18
`define OPC_ADDM    5'd19
`define OPC_SUBM    5'd20
`define OPC_MULM    5'd21     // 22 is unused and decodes as nop
`define OPC_UNRLL   5'd23
`define OPC_UNRLU   5'd24
`define OPC_RLLM    5'd25

// control word bits, packed from the top
`define CW_ADD         37
`define CW_OR          36
`define CW_NOT         35
`define CW_ANDBIT      34
`define CW_ORBIT       33
`define CW_NOTBIT      32
`define CW_AND         31
`define CW_CARRY_IN    30
`define CW_OP2_COMPL   29
`define CW_JUMP        28
`define CW_COMPARE     27
`define CW_SHL         26
`define CW_LOGIC       25
`define CW_STORE       24
`define CW_LOAD        23
`define CW_WRITE_RF    22
`define CW_JGT         21
`define CW_JLT         20
`define CW_JEQ         19
`define CW_JCARRY      18
`define CW_JUNCOND     17
`define CW_LD_IMM      16
`define CW_IMM_LSB     8      // immediate occupies 15:8
`define CW_MUL         7
`define CW_RNS_ALU     6
`define CW_UNRL        5
`define CW_RLLM        4
`define CW_RNS_DEST    3
`define CW_OP1_FILE    2
`define CW_OP2_FILE    1
`define CW_UNRL_LOWER  0

`endif
